// File: rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcode groups, instr[6:2]
    typedef enum logic [4:0]
    {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_t;

    // [4] arith shift, [3:2] group (0x compare, [2] inverts), [1:0] operation
    typedef logic [4:0] alu_ctrl_t;

    localparam logic [1:0] ALU_GRP_ARITH = 2'b10;
    localparam logic [1:0] ALU_GRP_BITS  = 2'b11;

    localparam logic [1:0] ALU_OP_EQ  = 2'b00;
    localparam logic [1:0] ALU_OP_LTS = 2'b01;
    localparam logic [1:0] ALU_OP_LTU = 2'b10;
    localparam logic [1:0] ALU_OP_ADD = 2'b00;
    localparam logic [1:0] ALU_OP_SUB = 2'b01;
    localparam logic [1:0] ALU_OP_SHL = 2'b10;
    localparam logic [1:0] ALU_OP_SHR = 2'b11;
    localparam logic [1:0] ALU_OP_XOR = 2'b00;
    localparam logic [1:0] ALU_OP_OR  = 2'b01;
    localparam logic [1:0] ALU_OP_AND = 2'b10;

    localparam alu_ctrl_t ALU_EQ  = {3'b000, ALU_OP_EQ};
    localparam alu_ctrl_t ALU_LTS = {3'b000, ALU_OP_LTS};
    localparam alu_ctrl_t ALU_LTU = {3'b000, ALU_OP_LTU};
    localparam alu_ctrl_t ALU_NE  = {3'b001, ALU_OP_EQ};
    localparam alu_ctrl_t ALU_GE  = {3'b001, ALU_OP_LTS};
    localparam alu_ctrl_t ALU_GEU = {3'b001, ALU_OP_LTU};
    localparam alu_ctrl_t ALU_ADD = {1'b0, ALU_GRP_ARITH, ALU_OP_ADD};
    localparam alu_ctrl_t ALU_SUB = {1'b0, ALU_GRP_ARITH, ALU_OP_SUB};
    localparam alu_ctrl_t ALU_SLL = {1'b0, ALU_GRP_ARITH, ALU_OP_SHL};
    localparam alu_ctrl_t ALU_SRL = {1'b0, ALU_GRP_ARITH, ALU_OP_SHR};
    localparam alu_ctrl_t ALU_SRA = {1'b1, ALU_GRP_ARITH, ALU_OP_SHR};
    localparam alu_ctrl_t ALU_XOR = {1'b0, ALU_GRP_BITS, ALU_OP_XOR};
    localparam alu_ctrl_t ALU_OR  = {1'b0, ALU_GRP_BITS, ALU_OP_OR};
    localparam alu_ctrl_t ALU_AND = {1'b0, ALU_GRP_BITS, ALU_OP_AND};

    typedef enum logic { OP1_REG, OP1_PC } op1_sel_t;

    typedef enum logic [2:0] { OP2_REG, OP2_I, OP2_U, OP2_J, OP2_S } op2_sel_t;

    typedef enum logic [1:0] { RES_ALU, RES_MEM, RES_PC4 } res_src_t;

    typedef enum logic [2:0]
    {
        STEP_FETCH, STEP_RS, STEP_ALU1, STEP_ALU2, STEP_MEM, STEP_WR
    } step_t;

    // funct3[1:0] of loads and stores
    typedef enum logic [1:0] { SIZE_BYTE, SIZE_HALF, SIZE_WORD } mem_size_t;

endpackage

// File: rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder
(
    input  rv_pkg::word_t       i_instr,
    output rv_pkg::reg_addr_t   o_rs1,
    output rv_pkg::reg_addr_t   o_rs2,
    output rv_pkg::reg_addr_t   o_rd,
    output rv_pkg::word_t       o_imm_i,
    output rv_pkg::word_t       o_imm_s,
    output rv_pkg::word_t       o_imm_b,
    output rv_pkg::word_t       o_imm_u,
    output rv_pkg::word_t       o_imm_j,
    output logic [2:0]          o_funct3,
    output rv_pkg::alu_ctrl_t   o_alu_ctrl,
    output rv_pkg::op1_sel_t    o_op1_sel,
    output rv_pkg::op2_sel_t    o_op2_sel,
    output rv_pkg::res_src_t    o_res_src,
    output logic                o_reg_write,
    output logic                o_store,
    output logic                o_jal,
    output logic                o_jalr,
    output logic                o_branch
);
    import rv_pkg::*;

    opcode_t    opc;
    logic       full;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       alu_valid;
    alu_ctrl_t  arith_ctrl;

    assign opc    = opcode_t'(i_instr[6:2]);
    assign full   = (i_instr[1:0] == 2'b11);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign alt    = (funct7 == 7'b0100000);

    // lui runs as x0 + imm_u
    assign o_rs1    = (full && opc == OPC_LUI) ? '0 : i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_rd     = i_instr[11:7];
    assign o_funct3 = funct3;

    assign o_imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign o_imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign o_imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign o_imm_u = {i_instr[31:12], 12'b0};
    assign o_imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    // shared by op and op-imm
    always_comb
    begin
        case (funct3)
            3'b000:  arith_ctrl = (opc == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_ctrl = ALU_SLL;
            3'b010:  arith_ctrl = ALU_LTS;
            3'b011:  arith_ctrl = ALU_LTU;
            3'b100:  arith_ctrl = ALU_XOR;
            3'b101:  arith_ctrl = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_ctrl = ALU_OR;
            default: arith_ctrl = ALU_AND;
        endcase

        if (funct7 == 7'b0000000)
            alu_valid = 1'b1;
        else if (alt && (funct3 == 3'b101 || (opc == OPC_OP && funct3 == 3'b000)))
            alu_valid = 1'b1;
        else
            // funct7 is immediate data here
            alu_valid = (opc == OPC_OP_IMM) && (funct3 != 3'b001) && (funct3 != 3'b101);
    end

    always_comb
    begin
        o_alu_ctrl  = ALU_ADD;
        o_op1_sel   = OP1_REG;
        o_op2_sel   = OP2_REG;
        o_res_src   = RES_ALU;
        o_reg_write = 1'b0;
        o_store     = 1'b0;
        o_jal       = 1'b0;
        o_jalr      = 1'b0;
        o_branch    = 1'b0;

        if (full)
        begin
            case (opc)
                OPC_LOAD:
                begin
                    o_op2_sel   = OP2_I;
                    o_res_src   = RES_MEM;
                    o_reg_write = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
                end
                OPC_OP_IMM, OPC_OP:
                begin
                    o_alu_ctrl  = arith_ctrl;
                    o_op2_sel   = (opc == OPC_OP) ? OP2_REG : OP2_I;
                    o_reg_write = alu_valid;
                end
                OPC_AUIPC:
                begin
                    o_op1_sel   = OP1_PC;
                    o_op2_sel   = OP2_U;
                    o_reg_write = 1'b1;
                end
                OPC_LUI:
                begin
                    o_op2_sel   = OP2_U;
                    o_reg_write = 1'b1;
                end
                OPC_STORE:
                begin
                    o_op2_sel = OP2_S;
                    o_store   = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
                end
                OPC_BRANCH:
                begin
                    case (funct3)
                        3'b000:  o_alu_ctrl = ALU_EQ;
                        3'b001:  o_alu_ctrl = ALU_NE;
                        3'b100:  o_alu_ctrl = ALU_LTS;
                        3'b101:  o_alu_ctrl = ALU_GE;
                        3'b110:  o_alu_ctrl = ALU_LTU;
                        default: o_alu_ctrl = ALU_GEU;
                    endcase
                    o_branch = (funct3[2:1] != 2'b01);
                end
                OPC_JALR:
                begin
                    o_op2_sel   = OP2_I;
                    o_res_src   = RES_PC4;
                    o_jalr      = (funct3 == 3'b000);
                    o_reg_write = (funct3 == 3'b000);
                end
                OPC_JAL:
                begin
                    o_op1_sel   = OP1_PC;
                    o_op2_sel   = OP2_J;
                    o_res_src   = RES_PC4;
                    o_jal       = 1'b1;
                    o_reg_write = 1'b1;
                end
                default:
                begin
                    o_reg_write = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: rv_regs.sv
`timescale 1ns/1ns

module rv_regs
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  rv_pkg::reg_addr_t   i_rs1,
    input  rv_pkg::reg_addr_t   i_rs2,
    input  rv_pkg::reg_addr_t   i_rd,
    input  logic                i_write,
    input  rv_pkg::word_t       i_data,
    output rv_pkg::word_t       o_data1,
    output rv_pkg::word_t       o_data2
);
    import rv_pkg::*;

    word_t regs [32];

    // x0 is never stored, and nothing is written while in reset
    always_ff @(posedge i_clk)
    begin
        if (i_reset_n && i_write && (i_rd != '0))
            regs[i_rd] <= i_data;
    end

    always_ff @(posedge i_clk)
    begin
        o_data1 <= (i_rs1 == '0) ? '0 : regs[i_rs1];
        o_data2 <= (i_rs2 == '0) ? '0 : regs[i_rs2];
    end

endmodule

// File: rv_alu.sv
`timescale 1ns/1ns

module rv_alu
(
    input  logic                i_clk,
    input  rv_pkg::word_t       i_op1,
    input  rv_pkg::word_t       i_op2,
    input  rv_pkg::alu_ctrl_t   i_ctrl,
    output rv_pkg::word_t       o_result
);
    import rv_pkg::*;

    logic           sub_mode;
    word_t          op_b;
    logic [XLEN:0]  sum;
    logic           overflow;
    logic           cmp_raw;
    logic           cmp_res;
    word_t          shl;
    logic [XLEN:0]  shr;
    word_t          arith_res;
    word_t          bits_res;
    logic           cmp_q;
    word_t          arith_q;
    word_t          bits_q;
    logic [1:0]     grp_q;

    // one adder for add, sub and every compare
    assign sub_mode = !i_ctrl[3] || (i_ctrl[3:0] == {ALU_GRP_ARITH, ALU_OP_SUB});
    assign op_b     = sub_mode ? ~i_op2 : i_op2;
    assign sum      = {1'b0, i_op1} + {1'b0, op_b} + {{XLEN{1'b0}}, sub_mode};
    assign overflow = (i_op1[XLEN-1] ^ i_op2[XLEN-1]) & (i_op1[XLEN-1] ^ sum[XLEN-1]);

    assign shl = i_op1 << i_op2[4:0];
    assign shr = $signed({i_ctrl[4] & i_op1[XLEN-1], i_op1}) >>> i_op2[4:0];

    always_comb
    begin
        case (i_ctrl[1:0])
            ALU_OP_EQ:  cmp_raw = (i_op1 == i_op2);
            ALU_OP_LTS: cmp_raw = sum[XLEN-1] ^ overflow;
            ALU_OP_LTU: cmp_raw = !sum[XLEN];
            default:    cmp_raw = 1'b0;
        endcase
        // bne, bge, bgeu
        cmp_res = cmp_raw ^ i_ctrl[2];
    end

    always_comb
    begin
        case (i_ctrl[1:0])
            ALU_OP_ADD, ALU_OP_SUB: arith_res = sum[XLEN-1:0];
            ALU_OP_SHL:             arith_res = shl;
            default:                arith_res = shr[XLEN-1:0];
        endcase
    end

    always_comb
    begin
        case (i_ctrl[1:0])
            ALU_OP_XOR: bits_res = i_op1 ^ i_op2;
            ALU_OP_OR:  bits_res = i_op1 | i_op2;
            default:    bits_res = i_op1 & i_op2;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        cmp_q   <= cmp_res;
        arith_q <= arith_res;
        bits_q  <= bits_res;
        grp_q   <= i_ctrl[3:2];
    end

    always_comb
    begin
        case (grp_q)
            ALU_GRP_ARITH: o_result = arith_q;
            ALU_GRP_BITS:  o_result = bits_q;
            default:       o_result = {{(XLEN-1){1'b0}}, cmp_q};
        endcase
    end

endmodule

// File: rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu
(
    input  rv_pkg::word_t   i_addr,
    input  rv_pkg::word_t   i_store_val,
    input  logic [2:0]      i_funct3,
    input  rv_pkg::word_t   i_rdata,
    output rv_pkg::word_t   o_wdata,
    output logic [3:0]      o_sel,
    output rv_pkg::word_t   o_load_val
);
    import rv_pkg::*;

    mem_size_t      size;
    logic           sign;
    logic [7:0]     rd_byte;
    logic [15:0]    rd_half;

    assign size = mem_size_t'(i_funct3[1:0]);
    // lbu and lhu have funct3 bit 2 set
    assign sign = !i_funct3[2];

    always_comb
    begin
        case (size)
            SIZE_BYTE:
            begin
                o_wdata = {4{i_store_val[7:0]}};
                o_sel   = 4'b0001 << i_addr[1:0];
            end
            SIZE_HALF:
            begin
                o_wdata = {2{i_store_val[15:0]}};
                o_sel   = i_addr[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                o_wdata = i_store_val;
                o_sel   = 4'b1111;
            end
        endcase
    end

    assign rd_byte = i_rdata[{i_addr[1:0], 3'b000} +: 8];
    assign rd_half = i_addr[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb
    begin
        case (size)
            SIZE_BYTE: o_load_val = {{24{sign & rd_byte[7]}}, rd_byte};
            SIZE_HALF: o_load_val = {{16{sign & rd_half[15]}}, rd_half};
            default:   o_load_val = i_rdata;
        endcase
    end

endmodule

// File: rv_core.sv
`timescale 1ns/1ns

module rv_core
#(
    parameter rv_pkg::word_t RESET_ADDR = 32'h0000_0000
)
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    output rv_pkg::word_t   o_wb_adr,
    output rv_pkg::word_t   o_wb_dat,
    input  rv_pkg::word_t   i_wb_dat,
    output logic            o_wb_we,
    output logic [3:0]      o_wb_sel,
    input  logic            i_wb_ack
);
    import rv_pkg::*;

    step_t      step;
    step_t      step_nxt;
    word_t      pc;
    word_t      instr_buf;
    word_t      instr;
    reg_addr_t  dec_rs1, dec_rs2, dec_rd;
    word_t      dec_imm_i, dec_imm_s, dec_imm_b, dec_imm_u, dec_imm_j;
    logic [2:0] dec_funct3;
    alu_ctrl_t  dec_alu_ctrl;
    op1_sel_t   dec_op1_sel;
    op2_sel_t   dec_op2_sel;
    res_src_t   dec_res_src;
    logic       dec_reg_write, dec_store, dec_jal, dec_jalr, dec_branch;
    reg_addr_t  ex_rd;
    word_t      ex_imm_i, ex_imm_s, ex_imm_b, ex_imm_u, ex_imm_j;
    logic [2:0] ex_funct3;
    alu_ctrl_t  ex_alu_ctrl;
    op1_sel_t   ex_op1_sel;
    op2_sel_t   ex_op2_sel;
    res_src_t   ex_res_src;
    logic       ex_reg_write, ex_store, ex_jal, ex_jalr, ex_branch;
    word_t      reg_data1, reg_data2;
    word_t      alu_op1, alu_op2, alu_result;
    word_t      target;
    logic       take_target;
    word_t      mem_addr, mem_store_val, mem_wdata, load_val, wb_data;
    logic [3:0] mem_sel;

    always_comb
    begin
        case (step)
            STEP_FETCH: step_nxt = i_wb_ack ? STEP_RS : STEP_FETCH;
            STEP_RS:    step_nxt = STEP_ALU1;
            STEP_ALU1:  step_nxt = STEP_ALU2;
            STEP_ALU2:  step_nxt = STEP_MEM;
            STEP_MEM:   step_nxt = STEP_WR;
            default:    step_nxt = STEP_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            step <= STEP_FETCH;
        else
            step <= step_nxt;
    end

    // jumps and taken branches resolve at the end of WR
    assign take_target = ex_jal || ex_jalr || (ex_branch && alu_result[0]);

    always_comb
    begin
        if (ex_jalr)
            target = (reg_data1 + ex_imm_i) & ~32'd1;
        else if (ex_jal)
            target = pc + ex_imm_j;
        else
            target = pc + ex_imm_b;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= RESET_ADDR;
        else if (step == STEP_WR)
            pc <= take_target ? target : pc + 32'd4;
    end

    // fetched word is on the bus only during RS
    always_ff @(posedge i_clk)
    begin
        if (step == STEP_RS)
            instr_buf <= i_wb_dat;
    end

    assign instr = (step == STEP_RS) ? i_wb_dat : instr_buf;

    rv_decoder u_decoder
    (
        .i_instr        (instr),
        .o_rs1          (dec_rs1),
        .o_rs2          (dec_rs2),
        .o_rd           (dec_rd),
        .o_imm_i        (dec_imm_i),
        .o_imm_s        (dec_imm_s),
        .o_imm_b        (dec_imm_b),
        .o_imm_u        (dec_imm_u),
        .o_imm_j        (dec_imm_j),
        .o_funct3       (dec_funct3),
        .o_alu_ctrl     (dec_alu_ctrl),
        .o_op1_sel      (dec_op1_sel),
        .o_op2_sel      (dec_op2_sel),
        .o_res_src      (dec_res_src),
        .o_reg_write    (dec_reg_write),
        .o_store        (dec_store),
        .o_jal          (dec_jal),
        .o_jalr         (dec_jalr),
        .o_branch       (dec_branch)
    );

    always_ff @(posedge i_clk)
    begin
        ex_rd        <= dec_rd;
        ex_imm_i     <= dec_imm_i;
        ex_imm_s     <= dec_imm_s;
        ex_imm_b     <= dec_imm_b;
        ex_imm_u     <= dec_imm_u;
        ex_imm_j     <= dec_imm_j;
        ex_funct3    <= dec_funct3;
        ex_alu_ctrl  <= dec_alu_ctrl;
        ex_op1_sel   <= dec_op1_sel;
        ex_op2_sel   <= dec_op2_sel;
        ex_res_src   <= dec_res_src;
        ex_reg_write <= dec_reg_write;
        ex_store     <= dec_store;
        ex_jal       <= dec_jal;
        ex_jalr      <= dec_jalr;
        ex_branch    <= dec_branch;
    end

    rv_regs u_regs
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_rs1      (dec_rs1),
        .i_rs2      (dec_rs2),
        .i_rd       (ex_rd),
        .i_write    (ex_reg_write && (step == STEP_WR)),
        .i_data     (wb_data),
        .o_data1    (reg_data1),
        .o_data2    (reg_data2)
    );

    assign alu_op1 = (ex_op1_sel == OP1_PC) ? pc : reg_data1;

    always_comb
    begin
        case (ex_op2_sel)
            OP2_I:   alu_op2 = ex_imm_i;
            OP2_U:   alu_op2 = ex_imm_u;
            OP2_J:   alu_op2 = ex_imm_j;
            OP2_S:   alu_op2 = ex_imm_s;
            default: alu_op2 = reg_data2;
        endcase
    end

    rv_alu u_alu
    (
        .i_clk      (i_clk),
        .i_op1      (alu_op1),
        .i_op2      (alu_op2),
        .i_ctrl     (ex_alu_ctrl),
        .o_result   (alu_result)
    );

    always_ff @(posedge i_clk)
    begin
        mem_addr      <= alu_result;
        mem_store_val <= reg_data2;
    end

    rv_lsu u_lsu
    (
        .i_addr         (mem_addr),
        .i_store_val    (mem_store_val),
        .i_funct3       (ex_funct3),
        .i_rdata        (i_wb_dat),
        .o_wdata        (mem_wdata),
        .o_sel          (mem_sel),
        .o_load_val     (load_val)
    );

    always_comb
    begin
        case (ex_res_src)
            RES_MEM: wb_data = load_val;
            RES_PC4: wb_data = pc + 32'd4;
            default: wb_data = mem_addr;
        endcase
    end

    assign o_wb_adr = (step == STEP_MEM) ? mem_addr : pc;
    assign o_wb_dat = mem_wdata;
    assign o_wb_we  = (step == STEP_MEM) && ex_store;
    assign o_wb_sel = (step == STEP_MEM) ? mem_sel : 4'b1111;

endmodule

// File: tb_rv_tests.svh
localparam word_t MARKER = 32'h0000_0055;

function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic word_t enc_i(word_t imm, reg_addr_t rs1, logic [2:0] f3,
                                reg_addr_t rd, logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(word_t imm, reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic word_t enc_b(word_t imm, reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic word_t enc_j(word_t imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

// expected results from the RV32I rules
function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
        3'd0:    return alt ? x - y : x + y;
        3'd1:    return x << y[4:0];
        3'd2:    return {31'b0, $signed(x) < $signed(y)};
        3'd3:    return {31'b0, x < y};
        3'd4:    return x ^ y;
        3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6:    return x | y;
        default: return x & y;
    endcase
endfunction

function automatic logic branch_ref(logic [2:0] f3, word_t x, word_t y);
    case (f3)
        3'd0:    return x == y;
        3'd1:    return x != y;
        3'd4:    return $signed(x) < $signed(y);
        3'd5:    return $signed(x) >= $signed(y);
        3'd6:    return x < y;
        default: return x >= y;
    endcase
endfunction

task automatic put(word_t instr);
    mem[prog_pc[11:2]] = instr;
    prog_pc = prog_pc + 4;
endtask

task automatic load_const(reg_addr_t rd, word_t v);
    word_t hi;
    hi = v + 32'h800;
    put({hi[31:12], rd, 7'h37});
    put(enc_i(v, rd, 3'b000, rd, 7'h13));
endtask

// next result slot above DATA_BASE, x10 holds the base
task automatic store_expect(reg_addr_t rs2, word_t exp);
    put(enc_s(word_t'(exp_q.size() * 4), rs2, 5'd10, 3'b010));
    exp_q.push_back(exp);
    exp_sel.push_back(4'b1111);
endtask

task automatic skip_store(reg_addr_t rs2);
    put(enc_s(word_t'(exp_q.size() * 4), rs2, 5'd10, 3'b010));
    exp_q.push_back(fill_word(DATA_BASE[11:2] + exp_q.size()));
endtask

task automatic begin_test();
    @(posedge clk);
    #2 reset_n = 1'b0;
    for (int i = 0; i < 1024; i++)
        mem[i] = fill_word(i);
    exp_q.delete();
    exp_sel.delete();
    sel_log.delete();
    prog_pc = RESET_ADDR;
    put(enc_i(DATA_BASE, 5'd0, 3'b000, 5'd10, 7'h13));
endtask

task automatic run_program();
    word_t done_addr;
    int    cycles;
    int    hits;
    done_addr = prog_pc;
    put(enc_j(32'd0, 5'd0));
    repeat (10) @(posedge clk);
    #2 reset_n = 1'b1;
    check_word("o_wb_adr", RESET_ADDR, wb_adr);
    check_bit("o_wb_we", 1'b0, wb_we);
    cycles = 0;
    hits = 0;
    while (hits < 2)
    begin
        @(posedge clk);
        #2;
        hits = (wb_adr === done_addr) ? hits + 1 : 0;
        cycles++;
        if (cycles > WAIT_LIMIT)
        begin
            $display("timeout, the core never reached the final jump at %h", done_addr);
            fail_run();
        end
    end
    for (int k = 0; k < exp_q.size(); k++)
        check_word($sformatf("mem[%h]", DATA_BASE + 4 * k), exp_q[k],
                   mem[DATA_BASE[11:2] + k]);
    if (sel_log.size() != exp_sel.size())
    begin
        $display("saw %0d stores on the bus but expected %0d", sel_log.size(), exp_sel.size());
        fail_run();
    end
    for (int k = 0; k < exp_sel.size(); k++)
        check_sel($sformatf("o_wb_sel of store %0d", k), exp_sel[k], sel_log[k]);
endtask

task automatic test_alu_ops();
    word_t a;
    word_t b;
    word_t r;
    word_t op2;
    begin_test();
    a = $random(seed);
    b = $random(seed);
    r = $random(seed);
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int f3 = 0; f3 < 8; f3++)
        for (int alt = 0; alt < 2; alt++)
        begin
            if (alt == 1 && f3 != 0 && f3 != 5)
                continue;
            put(enc_r({1'b0, alt[0], 5'b0}, 5'd2, 5'd1, f3[2:0], 5'd3));
            store_expect(5'd3, alu_ref(f3[2:0], alt[0], a, b));
        end
    // immediate forms, shifts take a shamt
    for (int f3 = 0; f3 < 8; f3++)
        for (int alt = 0; alt < 2; alt++)
        begin
            if (alt == 1 && f3 != 5)
                continue;
            if (f3 == 1 || f3 == 5)
                op2 = {21'b0, alt[0], 5'b0, r[4:0]};
            else
                op2 = {{20{r[11]}}, r[11:0]};
            put(enc_i(op2, 5'd1, f3[2:0], 5'd3, 7'h13));
            store_expect(5'd3, alu_ref(f3[2:0], alt[0], a, op2));
        end
    run_program();
endtask

task automatic test_load_store();
    word_t d0;
    word_t d1;
    word_t w;
    word_t v;
    begin_test();
    d0 = $random(seed);
    d1 = $random(seed);
    w  = $random(seed) | 32'h8080_8080;
    v  = $random(seed);
    mem[DATA_BASE[11:2] + 32] = d0;
    mem[DATA_BASE[11:2] + 33] = d1;
    mem[DATA_BASE[11:2] + 34] = w;
    load_const(5'd5, v);
    put(enc_s(32'd129, 5'd5, 5'd10, 3'b000));
    exp_sel.push_back(4'b0010);
    put(enc_s(32'd134, 5'd5, 5'd10, 3'b001));
    exp_sel.push_back(4'b1100);
    put(enc_i(32'd139, 5'd10, 3'b000, 5'd6, 7'h03));
    store_expect(5'd6, {{24{w[31]}}, w[31:24]});
    put(enc_i(32'd139, 5'd10, 3'b100, 5'd6, 7'h03));
    store_expect(5'd6, {24'b0, w[31:24]});
    put(enc_i(32'd137, 5'd10, 3'b000, 5'd6, 7'h03));
    store_expect(5'd6, {{24{w[15]}}, w[15:8]});
    put(enc_i(32'd138, 5'd10, 3'b001, 5'd6, 7'h03));
    store_expect(5'd6, {{16{w[31]}}, w[31:16]});
    put(enc_i(32'd136, 5'd10, 3'b101, 5'd6, 7'h03));
    store_expect(5'd6, {16'b0, w[15:0]});
    put(enc_i(32'd136, 5'd10, 3'b010, 5'd6, 7'h03));
    store_expect(5'd6, w);
    run_program();
    check_word("byte store word", {d0[31:16], v[7:0], d0[7:0]}, mem[DATA_BASE[11:2] + 32]);
    check_word("half store word", {v[15:0], d1[15:0]}, mem[DATA_BASE[11:2] + 33]);
endtask

task automatic test_control_flow();
    word_t x1;
    word_t x2;
    word_t here;
    logic  taken;
    begin_test();
    x1 = 32'hFFFF_FFFB;
    x2 = 32'd3;
    load_const(5'd1, x1);
    load_const(5'd2, x2);
    load_const(5'd3, MARKER);
    // second pass compares x1 with itself
    for (int pass = 0; pass < 2; pass++)
        for (int f3 = 0; f3 < 8; f3++)
        begin
            if (f3 == 2 || f3 == 3)
                continue;
            put(enc_b(32'd8, (pass == 0) ? 5'd2 : 5'd1, 5'd1, f3[2:0]));
            taken = branch_ref(f3[2:0], x1, (pass == 0) ? x2 : x1);
            if (taken)
                skip_store(5'd3);
            else
                store_expect(5'd3, MARKER);
        end
    here = prog_pc;
    put(enc_j(32'd8, 5'd5));
    skip_store(5'd3);
    store_expect(5'd5, here + 4);
    here = prog_pc;
    put({20'd0, 5'd6, 7'h17});
    put(enc_i(32'd12, 5'd6, 3'b000, 5'd7, 7'h67));
    skip_store(5'd3);
    store_expect(5'd7, here + 8);
    run_program();
endtask

task automatic test_upper_imm();
    word_t u;
    word_t here;
    begin_test();
    for (int k = 0; k < 4; k++)
    begin
        u = $random(seed);
        put({u[19:0], 5'd5, 7'h37});
        store_expect(5'd5, {u[19:0], 12'b0});
        u = $random(seed);
        here = prog_pc;
        put({u[19:0], 5'd6, 7'h17});
        store_expect(5'd6, here + {u[19:0], 12'b0});
    end
    run_program();
endtask

// File: tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t RESET_ADDR = 32'h0000_0080;
    localparam word_t DATA_BASE  = 32'h0000_0400;
    localparam int    NUM_TESTS  = 4;
    localparam int    WAIT_LIMIT = 1500;

    logic       clk = 1'b0;
    logic       reset_n = 1'b0;
    word_t      wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r = '0;
    logic       wb_we;
    logic [3:0] wb_sel;
    logic       wb_ack = 1'b0;

    word_t      mem [1024];
    int         seed = 18;
    int         wait_cnt = 0;
    word_t      prog_pc;
    word_t      exp_q [$];
    logic [3:0] exp_sel [$];
    logic [3:0] sel_log [$];

    always #10 clk = ~clk;

    rv_core #(.RESET_ADDR(RESET_ADDR)) UUT
    (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .o_wb_adr   (wb_adr),
        .o_wb_dat   (wb_dat_w),
        .i_wb_dat   (wb_dat_r),
        .o_wb_we    (wb_we),
        .o_wb_sel   (wb_sel),
        .i_wb_ack   (wb_ack)
    );

    // registered read, lane writes, ack pulses with 0 to 3 idle cycles
    always @(posedge clk)
    begin
        wb_dat_r <= mem[wb_adr[11:2]];
        if (wb_we === 1'b1)
        begin
            for (int b = 0; b < 4; b++)
                if (wb_sel[b])
                    mem[wb_adr[11:2]][8*b +: 8] = wb_dat_w[8*b +: 8];
            sel_log.push_back(wb_sel);
        end
        if (wait_cnt == 0)
        begin
            wb_ack <= 1'b1;
            wait_cnt = $random(seed) & 3;
        end
        else
        begin
            wb_ack <= 1'b0;
            wait_cnt = wait_cnt - 1;
        end
    end

    function automatic word_t fill_word(int idx);
        return 32'hA5A5_0000 | word_t'(idx);
    endfunction

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp)
        begin
            $display("Error: time %0t %s expected %h actual %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_sel(string name, logic [3:0] exp, logic [3:0] act);
        if (act !== exp)
        begin
            $display("Error: time %0t %s expected %b actual %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp)
        begin
            $display("Error: time %0t %s expected %b actual %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    `include "tb_rv_tests.svh"

    initial
    begin
        #(NUM_TESTS * 2000 * 20);
        $display("watchdog expired, the tests did not finish in time");
        fail_run();
    end

    initial
    begin
        test_alu_ops();
        test_load_store();
        test_control_flow();
        test_upper_imm();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: build.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_regs.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f build.f --top-module tb_rv_core -Mdir obj_dir

run: compile
	./obj_dir/Vtb_rv_core

clean:
	rm -rf obj_dir
